// ==== tb.f ====
fm_pkg.sv
fm_mmr.sv
fm_timers.sv
fm_pg.sv
fm_top.sv
fm_properties.sv
tb_fm_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the FM core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_fm_top -f tb.f -Mdir "$BUILD_DIR" -o sim_fm
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_fm" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "** FAIL **" "$LOG"; then
    echo "run.sh: testbench reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi
echo "run.sh: simulation finished without failures"
exit 0

// ==== tb_fm_top.sv ====
/*
 * testbench for the reduced FM core
 *   clock, reset and random cen
 *   cycle model of registers, phase accumulators and timers
 *   directed and random register traffic, closing result line
 */

`timescale 1ns/1ns

module tb_fm_top;

    localparam int NUM_CH      = 3;
    localparam int BUSY_CYCLES = 32;
    localparam int WAIT_LIMIT  = 3000;

    logic       clk = 1'b0;
    logic       cen = 1'b0;
    logic       rst;
    logic       cs_n;
    logic       wr_n;
    logic       addr;
    logic [7:0] din;
    logic [7:0] dout;
    logic       irq_n;
    logic       snd_sample;
    logic [9:0] phase;
    logic [1:0] phase_ch;
    logic       phase_valid;

    int seed     = 32'hc2f6;
    int cen_seed = 32'hc2f6;
    bit cen_run  = 1'b0;
    int checks       = 0;
    int value_errors = 0;   // per-cycle compare
    int seq_errors   = 0;   // directed checks
    int timeouts     = 0;
    int total;

    // model state
    logic [7:0]  m_sel;
    logic [10:0] m_fnum [4];
    logic [2:0]  m_block [4];
    logic [19:0] m_acc [4];
    logic [2:0]  m_blk_latch;
    logic [2:0]  m_fhi_latch;
    logic [9:0]  m_val_a;
    logic [9:0]  m_cnt_a;
    logic [7:0]  m_val_b;
    logic [7:0]  m_cnt_b;
    logic [3:0]  m_pre_b;
    logic        m_load_a, m_load_b, m_en_a, m_en_b, m_clr_a, m_clr_b;
    logic        m_load_a_q, m_load_b_q, m_flag_a, m_flag_b;
    logic [1:0]  m_slot;
    logic        m_valid;
    logic [9:0]  m_phase;
    logic [1:0]  m_phase_ch;
    int          m_busy;
    int          ticks_a;       // samples since load A rose
    int          ovf_b_count;
    bit          started = 1'b0;

    fm_top #(
        .NUM_CH      (NUM_CH),
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_fm_top (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .cs_n        (cs_n),
        .wr_n        (wr_n),
        .addr        (addr),
        .din         (din),
        .dout        (dout),
        .irq_n       (irq_n),
        .snd_sample  (snd_sample),
        .phase       (phase),
        .phase_ch    (phase_ch),
        .phase_valid (phase_valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        int r;
        r = $random(cen_seed);
        cen <= cen_run && (r[1:0] != 2'b00);    // about 3 of 4 cycles
    end

    task automatic reset_model;
        for (int i = 0; i < 4; i++) begin
            m_fnum[i]  = '0;
            m_block[i] = '0;
            m_acc[i]   = '0;
        end
        m_sel = '0;
        {m_blk_latch, m_fhi_latch, m_val_a, m_cnt_a, m_val_b, m_cnt_b, m_pre_b} = '0;
        {m_load_a, m_load_b, m_en_a, m_en_b, m_clr_a, m_clr_b} = '0;
        {m_load_a_q, m_load_b_q, m_flag_a, m_flag_b} = '0;
        m_slot  = '0;
        m_valid = 1'b0;
        m_busy  = 0;
    endtask

    task automatic step_timers(input logic tick);
        logic ovf_a;
        logic ovf_b;
        ovf_a = 1'b0;
        ovf_b = 1'b0;
        if (m_load_a && !m_load_a_q) begin
            m_cnt_a = m_val_a;
            ticks_a = 0;
        end else if (tick && m_load_a) begin
            ticks_a++;
            ovf_a   = m_cnt_a == 10'h3ff;
            m_cnt_a = ovf_a ? m_val_a : m_cnt_a + 10'd1;
        end
        if (m_load_b && !m_load_b_q) begin
            m_pre_b = 4'd0;
            m_cnt_b = m_val_b;
        end else if (tick && m_load_b) begin
            if (m_pre_b == 4'hf) begin      // B counts every 16th sample
                ovf_b   = m_cnt_b == 8'hff;
                m_cnt_b = ovf_b ? m_val_b : m_cnt_b + 8'd1;
            end
            m_pre_b = m_pre_b + 4'd1;
        end
        if (ovf_b) begin
            ovf_b_count++;
        end
        m_flag_a   = m_clr_a ? 1'b0 : (m_flag_a || (ovf_a && m_en_a));
        m_flag_b   = m_clr_b ? 1'b0 : (m_flag_b || (ovf_b && m_en_b));
        m_load_a_q = m_load_a;
        m_load_b_q = m_load_b;
    endtask

    task automatic apply_write;
        logic [1:0] ch;
        bit         ok;
        ch = m_sel[1:0];
        ok = int'(ch) < NUM_CH;
        if (!addr) begin
            m_sel = din;
        end else if (m_sel == 8'h24) begin
            m_val_a[9:2] = din;
        end else if (m_sel == 8'h25) begin
            m_val_a[1:0] = din[1:0];
        end else if (m_sel == 8'h26) begin
            m_val_b = din;
        end else if (m_sel == 8'h27) begin
            {m_clr_b, m_clr_a, m_en_b, m_en_a, m_load_b, m_load_a} = din[5:0];
        end else if (ok && (m_sel & 8'hfc) == 8'ha4) begin
            m_blk_latch = din[5:3];
            m_fhi_latch = din[2:0];
        end else if (ok && (m_sel & 8'hfc) == 8'ha0) begin
            m_fnum[ch]  = {m_fhi_latch, din};   // commit the latch
            m_block[ch] = m_blk_latch;
        end
    endtask

    // model steps on the same edge as the DUT, old config first
    always @(posedge clk) begin
        logic        tick;
        logic        wr;
        logic [19:0] inc;
        tick    = (m_slot == 2'd0) && cen;
        wr      = !cs_n && !wr_n;
        started = 1'b1;
        if (rst) begin
            reset_model();
        end else begin
            m_valid = cen;
            if (cen) begin
                inc            = ({9'd0, m_fnum[m_slot]} << m_block[m_slot]) >> 1;
                m_acc[m_slot]  = m_acc[m_slot] + inc;
                m_phase        = m_acc[m_slot][19:10];
                m_phase_ch     = m_slot;
                m_slot = (m_slot == 2'(NUM_CH - 1)) ? 2'd0 : m_slot + 2'd1;
            end
            step_timers(tick);
            if (wr && addr) begin
                m_busy = BUSY_CYCLES;
            end else if (cen && m_busy > 0) begin
                m_busy--;
            end
            m_clr_a = 1'b0;
            m_clr_b = 1'b0;
            if (wr) begin
                apply_write();
            end
        end
    end

    always @(negedge clk) begin
        logic [7:0] exp_dout;
        if (started) begin
            exp_dout = {m_busy != 0, 5'd0, m_flag_b, m_flag_a};
            checks++;
            if (dout !== exp_dout) begin
                value_errors++;
                $display("Fail %0t ns: dout %02h, expected %02h", $time, dout, exp_dout);
            end
            if (irq_n !== !(m_flag_a || m_flag_b)) begin
                value_errors++;
                $display("Fail %0t ns: irq_n is %b against the flags", $time, irq_n);
            end
            if (snd_sample !== (m_slot == 2'd0 && cen)) begin
                value_errors++;
                $display("Fail %0t ns: snd_sample is %b", $time, snd_sample);
            end
            if (phase_valid !== m_valid) begin
                value_errors++;
                $display("Fail %0t ns: phase_valid is %b", $time, phase_valid);
            end else if (m_valid && (phase !== m_phase || phase_ch !== m_phase_ch)) begin
                value_errors++;
                $display("Fail %0t ns: phase %03h ch %0d, expected %03h ch %0d",
                         $time, phase, phase_ch, m_phase, m_phase_ch);
            end
        end
    end

    task automatic write_reg(input logic [7:0] num, input logic [7:0] val);
        int n;
        n = 0;
        @(negedge clk);
        while (dout[7] && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (dout[7]) begin
            timeouts++;
            $display("timeout: busy never fell before the write to register %02h", num);
        end
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        addr <= 1'b0;
        din  <= num;
        @(posedge clk);
        addr <= 1'b1;
        din  <= val;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    // counts cen-high cycles until busy drops
    task automatic measure_busy;
        int n;
        int cen_cycles;
        n          = 0;
        cen_cycles = 0;
        @(negedge clk);
        while (dout[7] && n < WAIT_LIMIT) begin
            if (cen) begin
                cen_cycles++;
            end
            @(negedge clk);
            n++;
        end
        if (dout[7]) begin
            timeouts++;
            $display("timeout: busy stayed high while measuring its length");
        end else if (cen_cycles != BUSY_CYCLES) begin
            seq_errors++;
            $display("Fail %0t ns: busy lasted %0d cen cycles", $time, cen_cycles);
        end
    endtask

    task automatic wait_flag(input logic [2:0] idx);
        int n;
        n = 0;
        @(negedge clk);
        while (!dout[idx] && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!dout[idx]) begin
            timeouts++;
            $display("timeout: status bit %0d never set", idx);
        end
    endtask

    task automatic wait_b_overflow;
        int n;
        int start;
        n     = 0;
        start = ovf_b_count;
        @(negedge clk);
        while (ovf_b_count == start && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ovf_b_count == start) begin
            timeouts++;
            $display("timeout: timer B never overflowed");
        end
    endtask

    initial begin
        int         r;
        logic [9:0] va;
        logic [7:0] vb;
        rst  = 1'b1;
        cs_n = 1'b1;
        wr_n = 1'b1;
        addr = 1'b0;
        din  = 8'h00;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (dout !== 8'h00 || irq_n !== 1'b1 || phase_valid !== 1'b0 || snd_sample !== 1'b0) begin
            seq_errors++;
            $display("Fail %0t ns: outputs not at their reset values", $time);
        end
        cen_run = 1'b1;

        // channel 3 is written too and must change nothing
        for (int ch = 0; ch < 4; ch++) begin
            r = $random(seed);
            write_reg(8'ha4 + 8'(ch), {2'b00, r[5:0]});
            write_reg(8'ha0 + 8'(ch), r[15:8]);
        end
        // latch still holds channel 2's high byte
        write_reg(8'ha0, r[23:16]);
        measure_busy();
        repeat (200) @(posedge clk);

        r  = $random(seed);
        va = 10'h3ff - {7'd0, r[2:0]};
        write_reg(8'h24, va[9:2]);
        write_reg(8'h25, {6'd0, va[1:0]});
        write_reg(8'h27, 8'h05);                // load A, irq enable A
        wait_flag(3'd0);
        if (ticks_a != 1024 - int'(va)) begin
            seq_errors++;
            $display("Fail %0t ns: flag A after %0d samples, value_a %0d", $time, ticks_a, va);
        end
        write_reg(8'h27, 8'h10);                // stop A, clear flag
        repeat (2) @(negedge clk);
        if (dout[0] !== 1'b0) begin
            seq_errors++;
            $display("Fail %0t ns: flag A still set after clear", $time);
        end

        r  = $random(seed);
        vb = 8'hfe | {7'd0, r[0]};
        write_reg(8'h26, vb);
        write_reg(8'h27, 8'h02);                // B runs, irq off
        wait_b_overflow();
        if (dout[1] !== 1'b0 || irq_n !== 1'b1) begin
            seq_errors++;
            $display("Fail %0t ns: flag B set with its enable low", $time);
        end
        write_reg(8'h27, 8'h0a);
        wait_flag(3'd1);
        write_reg(8'h27, 8'h20);

        for (int i = 0; i < 60; i++) begin
            r = $random(seed);
            case (r[2:0])
                3'd0: write_reg(8'h24, r[15:8]);
                3'd1: write_reg(8'h25, r[15:8]);
                3'd2: write_reg(8'h26, r[15:8]);
                3'd3: write_reg(8'h27, {2'b00, r[13:8]});
                3'd4: write_reg(8'ha4 + {6'd0, r[9:8]}, r[23:16]);
                3'd5: write_reg(8'ha0 + {6'd0, r[9:8]}, r[23:16]);
                default: repeat (32) @(posedge clk);
            endcase
        end
        repeat (50) @(posedge clk);

        total = value_errors + seq_errors + timeouts + u_fm_top.u_props.fail_total;
        $display("checks %0d, value errors %0d, directed errors %0d, timeouts %0d, assertions %0d",
                 checks, value_errors, seq_errors, timeouts, u_fm_top.u_props.fail_total);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== fm_properties.sv ====
/*
 * concurrent checks bound into the FM chip top
 *   reset state, busy length, interrupt and phase tag
 */

`timescale 1ns/1ns

module fm_properties #(
    parameter int NUM_CH      = 3,
    parameter int BUSY_CYCLES = 32
) (
    input logic       clk,
    input logic       rst,
    input logic       cen,
    input logic       write,
    input logic       addr,
    input logic       busy,
    input logic       flag_a,
    input logic       flag_b,
    input logic       irq_n,
    input logic       snd_sample,
    input logic       phase_valid,
    input logic [1:0] phase_ch
);

    int busy_run;           // cen-high cycles since busy was set
    int fail_rst  = 0;
    int fail_busy = 0;
    int fail_irq  = 0;
    int fail_ch   = 0;
    int fail_total;

    assign fail_total = fail_rst + fail_busy + fail_irq + fail_ch;

    always_ff @(posedge clk) begin
        if (rst || !busy || (write && addr)) begin
            busy_run <= 0;
        end else if (cen) begin
            busy_run <= busy_run + 1;
        end
    end

    assert property (@(posedge clk) rst |=> irq_n)
        else begin
            $error("irq_n low in the cycle after reset");
            fail_rst++;
        end

    assert property (@(posedge clk) disable iff (rst) busy_run <= BUSY_CYCLES)
        else begin
            $error("busy held longer than the busy count");
            fail_busy++;
        end

    // a flag can only rise on an overflow, and overflows come with a sample
    assert property (@(posedge clk) disable iff (rst) $fell(irq_n) |-> $past(snd_sample))
        else begin
            $error("irq_n fell away from a sample pulse");
            fail_irq++;
        end

    assert property (@(posedge clk) disable iff (rst) phase_valid |-> (int'(phase_ch) < NUM_CH))
        else begin
            $error("phase tagged with a channel out of range");
            fail_ch++;
        end

endmodule

bind fm_top fm_properties #(
    .NUM_CH      (NUM_CH),
    .BUSY_CYCLES (BUSY_CYCLES)
) u_props (
    .clk         (clk),
    .rst         (rst),
    .cen         (cen),
    .write       (write),
    .addr        (addr),
    .busy        (busy),
    .flag_a      (flag_a),
    .flag_b      (flag_b),
    .irq_n       (irq_n),
    .snd_sample  (snd_sample),
    .phase_valid (phase_valid),
    .phase_ch    (phase_ch)
);

// ==== fm_top.sv ====
/*
 * chip top of the reduced FM core
 *   CPU write strobe and status byte
 *   sample pulse from slot zero
 *   register map, timers and phase generator instances
 */

`timescale 1ns/1ns

module fm_top #(
    parameter int NUM_CH      = 3,
    parameter int BUSY_CYCLES = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen,
    input  logic                           cs_n,
    input  logic                           wr_n,
    input  logic                           addr,
    input  logic [7:0]                     din,
    output logic [7:0]                     dout,
    output logic                           irq_n,
    output logic                           snd_sample,
    output logic [fm_pkg::PHASE_OUT_W-1:0] phase,
    output logic [1:0]                     phase_ch,
    output logic                           phase_valid
);

    fm_pkg::fm_slot_t      slot;
    fm_pkg::fm_timer_cfg_t timer_cfg;
    logic                  write;
    logic                  busy;
    logic                  flag_a;
    logic                  flag_b;

    assign write      = ~cs_n & ~wr_n;
    assign snd_sample = slot.zero & cen;    // once per full slot round
    assign dout       = {busy, 5'd0, flag_b, flag_a};

    fm_mmr #(
        .NUM_CH      (NUM_CH),
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_mmr (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .write     (write),
        .addr      (addr),
        .din       (din),
        .busy      (busy),
        .slot      (slot),
        .timer_cfg (timer_cfg)
    );

    fm_timers u_timers (
        .clk    (clk),
        .rst    (rst),
        .tick_a (snd_sample),
        .cfg    (timer_cfg),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .irq_n  (irq_n)
    );

    fm_pg #(
        .NUM_CH (NUM_CH)
    ) u_pg (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .slot        (slot),
        .phase       (phase),
        .phase_ch    (phase_ch),
        .phase_valid (phase_valid)
    );

endmodule

// ==== fm_pg.sv ====
/*
 * phase generator, one accumulator per channel
 *   block shifted increment for the current slot
 *   registered phase with channel tag and valid
 */

`timescale 1ns/1ns

module fm_pg #(
    parameter int NUM_CH = 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen,
    input  fm_pkg::fm_slot_t               slot,
    output logic [fm_pkg::PHASE_OUT_W-1:0] phase,
    output logic [1:0]                     phase_ch,
    output logic                           phase_valid
);

    localparam int ACC_W = fm_pkg::PHASE_ACC_W;

    logic [ACC_W-1:0] acc [NUM_CH];
    logic [ACC_W-1:0] fnum_ext;
    logic [ACC_W-1:0] fnum_shl;
    logic [ACC_W-1:0] inc;
    logic [ACC_W-1:0] acc_upd;

    // fnum << block, then halved
    assign fnum_ext = ACC_W'(slot.fnum);
    assign fnum_shl = fnum_ext << slot.block;
    assign inc      = fnum_shl >> 1;
    assign acc_upd  = acc[slot.ch] + inc;   // wraps at ACC_W bits

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                acc[i] <= '0;
            end
        end else if (cen) begin
            acc[slot.ch] <= acc_upd;
        end
    end

    // one clk behind the slot, next slot computes meanwhile
    always_ff @(posedge clk) begin
        if (rst) begin
            phase       <= '0;
            phase_ch    <= '0;
            phase_valid <= 1'b0;
        end else begin
            phase_valid <= cen;
            if (cen) begin
                phase    <= acc_upd[ACC_W-1 -: fm_pkg::PHASE_OUT_W];
                phase_ch <= slot.ch;
            end
        end
    end

endmodule

// ==== fm_timers.sv ====
/*
 * chip timers A and B
 *   10 bit counter A ticked by the sample pulse
 *   8 bit counter B behind a 16 sample prescaler
 *   overflow flags and interrupt output
 */

`timescale 1ns/1ns

module fm_timers (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick_a,
    input  fm_pkg::fm_timer_cfg_t cfg,
    output logic                  flag_a,
    output logic                  flag_b,
    output logic                  irq_n
);

    logic [9:0] cnt_a;
    logic [7:0] cnt_b;
    logic [3:0] pre_b;
    logic       load_a_q;
    logic       load_b_q;
    logic       rise_a;
    logic       rise_b;
    logic       tick_b;
    logic       ovf_a;
    logic       ovf_b;

    assign rise_a = cfg.load_a & ~load_a_q;
    assign rise_b = cfg.load_b & ~load_b_q;

    // B moves once every 16 samples
    assign tick_b = tick_a & cfg.load_b & ~rise_b & (pre_b == 4'hF);

    assign ovf_a = tick_a & cfg.load_a & ~rise_a & (cnt_a == 10'h3FF);
    assign ovf_b = tick_b & (cnt_b == 8'hFF);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_a_q <= 1'b0;
            load_b_q <= 1'b0;
        end else begin
            load_a_q <= cfg.load_a;
            load_b_q <= cfg.load_b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= '0;
        end else if (rise_a || ovf_a) begin
            cnt_a <= cfg.value_a;
        end else if (tick_a && cfg.load_a) begin
            cnt_a <= cnt_a + 10'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_b <= '0;
            cnt_b <= '0;
        end else if (rise_b) begin
            pre_b <= '0;            // prescaler restarts with the load
            cnt_b <= cfg.value_b;
        end else if (tick_a && cfg.load_b) begin
            pre_b <= pre_b + 4'd1;
            if (ovf_b) begin
                cnt_b <= cfg.value_b;
            end else if (tick_b) begin
                cnt_b <= cnt_b + 8'd1;
            end
        end
    end

    // clear has priority over a new overflow
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (cfg.clr_a) begin
                flag_a <= 1'b0;
            end else if (ovf_a && cfg.irq_en_a) begin
                flag_a <= 1'b1;
            end
            if (cfg.clr_b) begin
                flag_b <= 1'b0;
            end else if (ovf_b && cfg.irq_en_b) begin
                flag_b <= 1'b1;
            end
        end
    end

    assign irq_n = ~(flag_a | flag_b);

endmodule

// ==== fm_mmr.sv ====
/*
 * register map of the FM core
 *   address latch and data write decode
 *   fnum high latch and per-channel fnum/block storage
 *   timer registers, busy countdown, slot counter
 */

`timescale 1ns/1ns

module fm_mmr #(
    parameter int NUM_CH      = 3,
    parameter int BUSY_CYCLES = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic                  write,
    input  logic                  addr,
    input  logic [7:0]            din,
    output logic                  busy,
    output fm_pkg::fm_slot_t      slot,
    output fm_pkg::fm_timer_cfg_t timer_cfg
);

    localparam int BUSY_W = $clog2(BUSY_CYCLES + 1);
    localparam int FHI_W  = fm_pkg::FNUM_W - 8;     // fnum bits held in the latch

    fm_pkg::fm_reg_e sel_reg;
    logic [7:0]      sel_num;
    logic [1:0]      sel_ch;
    logic            data_wr;
    logic            ch_ok;
    logic            is_fnum_hi;
    logic            is_fnum_lo;

    logic [fm_pkg::BLOCK_W-1:0] blk_latch;
    logic [FHI_W-1:0]           fhi_latch;
    logic [fm_pkg::FNUM_W-1:0]  fnum_mem  [NUM_CH];
    logic [fm_pkg::BLOCK_W-1:0] block_mem [NUM_CH];

    fm_pkg::fm_timer_cfg_t timer_q;
    logic [BUSY_W-1:0]     busy_cnt;
    logic [1:0]            slot_cnt;

    assign data_wr = write & addr;
    assign sel_num = 8'(sel_reg);
    assign sel_ch  = sel_num[1:0];
    assign ch_ok   = {1'b0, sel_ch} < 3'(NUM_CH);   // upper channels ignored

    // channel registers come in groups of four
    assign is_fnum_hi = (sel_num & 8'hFC) == 8'(fm_pkg::REG_FNUM_HI);
    assign is_fnum_lo = (sel_num & 8'hFC) == 8'(fm_pkg::REG_FNUM_LO);

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg <= fm_pkg::fm_reg_e'(8'h00);
        end else if (write && !addr) begin
            sel_reg <= fm_pkg::fm_reg_e'(din);
        end
    end

    // high byte waits in the latch until the low byte commits it
    always_ff @(posedge clk) begin
        if (rst) begin
            blk_latch <= '0;
            fhi_latch <= '0;
            for (int i = 0; i < NUM_CH; i++) begin
                fnum_mem[i]  <= '0;
                block_mem[i] <= '0;
            end
        end else if (data_wr && ch_ok) begin
            if (is_fnum_hi) begin
                blk_latch <= din[5:3];
                fhi_latch <= din[2:0];
            end else if (is_fnum_lo) begin
                fnum_mem[sel_ch]  <= {fhi_latch, din};
                block_mem[sel_ch] <= blk_latch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            timer_q <= '0;
        end else begin
            timer_q.clr_a <= 1'b0;  // clears are never stored
            timer_q.clr_b <= 1'b0;
            if (data_wr) begin
                case (sel_reg)
                    fm_pkg::REG_TIMER_A_HI: timer_q.value_a[9:2] <= din;
                    fm_pkg::REG_TIMER_A_LO: timer_q.value_a[1:0] <= din[1:0];
                    fm_pkg::REG_TIMER_B:    timer_q.value_b      <= din;
                    fm_pkg::REG_TIMER_CTRL: begin
                        timer_q.load_a   <= din[0];
                        timer_q.load_b   <= din[1];
                        timer_q.irq_en_a <= din[2];
                        timer_q.irq_en_b <= din[3];
                        timer_q.clr_a    <= din[4];
                        timer_q.clr_b    <= din[5];
                    end
                    default: ;
                endcase
            end
        end
    end

    assign timer_cfg = timer_q;

    // a new write restarts the count even while busy
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(BUSY_CYCLES);
        end else if (cen && busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = busy_cnt != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (cen) begin
            slot_cnt <= (slot_cnt == 2'(NUM_CH - 1)) ? 2'd0 : slot_cnt + 2'd1;
        end
    end

    // config of the current slot straight from storage
    assign slot.ch    = slot_cnt;
    assign slot.fnum  = fnum_mem[slot_cnt];
    assign slot.block = block_mem[slot_cnt];
    assign slot.zero  = slot_cnt == 2'd0;

endmodule

// ==== fm_pkg.sv ====
/*
 * shared definitions for the FM core
 *   register numbers of the CPU map
 *   per-slot channel config and timer config structs
 *   datapath widths for mmr, phase generator and top
 */

package fm_pkg;

    localparam int FNUM_W      = 11;
    localparam int BLOCK_W     = 3;
    localparam int PHASE_ACC_W = 20;
    localparam int PHASE_OUT_W = 10;

    // register numbers, selected by an address write
    typedef enum logic [7:0] {
        REG_TIMER_A_HI = 8'h24,     // value A bits 9..2
        REG_TIMER_A_LO = 8'h25,     // value A bits 1..0
        REG_TIMER_B    = 8'h26,
        REG_TIMER_CTRL = 8'h27,     // load, irq enable, flag clear
        REG_FNUM_LO    = 8'hA0,     // base, +ch commits a channel
        REG_FNUM_HI    = 8'hA4      // base, +ch fills the shared latch
    } fm_reg_e;

    // channel config of the slot being processed now
    typedef struct packed {
        logic [1:0]         ch;
        logic [FNUM_W-1:0]  fnum;
        logic [BLOCK_W-1:0] block;
        logic               zero;   // high in slot 0
    } fm_slot_t;

    typedef struct packed {
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       clr_a;          // single clk pulse
        logic       clr_b;          // single clk pulse
    } fm_timer_cfg_t;

endpackage
